// File: Bender.yml
package:
  name: singleCycleCpu

sources:
  - rtl/mipsPkg.sv
  - rtl/fetchUnit.sv
  - rtl/instrMem.sv
  - rtl/opcodeControl.sv
  - rtl/regFile.sv
  - rtl/mipsAlu.sv
  - rtl/dataMem.sv
  - rtl/singleCycleCpu.sv
  - target: simulation
    files:
      - sim/clockGen.sv
      - sim/tbSingleCycleCpu.sv

// File: rtl/dataMem.sv
`timescale 1ns/10ps

module dataMem import mipsPkg::*; #(
    parameter int DmemDepth = 256
) (
    input  logic                 clk,
    input  logic [DataWidth-1:0] address,
    input  logic                 writeEnable,
    input  logic [DataWidth-1:0] writeData,
    output logic [DataWidth-1:0] readData
);

    // power-of-two depth, address wraps on the index slice
    localparam int IdxWidth = $clog2(DmemDepth);

    logic [DataWidth-1:0] mem [DmemDepth];
    logic [IdxWidth-1:0]  wordIdx;

    // untouched words read back as zero
    initial begin
        for (int i = 0; i < DmemDepth; i++) begin
            mem[i] = '0;
        end
    end

    // byte address in, word index out
    assign wordIdx  = address[IdxWidth+1:2];
    assign readData = mem[wordIdx];

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            mem[wordIdx] <= writeData;
        end
    end

endmodule

// File: rtl/fetchUnit.sv
`timescale 1ns/10ps

module fetchUnit import mipsPkg::*; (
    input  logic                 clk,
    input  logic                 arstN,
    input  ctrlT                 ctrl,
    input  logic                 zero,
    input  logic [DataWidth-1:0] rsData,
    input  logic [DataWidth-1:0] immExt,
    input  logic [25:0]          jumpTarget,
    output logic [DataWidth-1:0] pc,
    output logic [DataWidth-1:0] pcPlusFour
);

    logic [DataWidth-1:0] branchTarget;
    logic [DataWidth-1:0] jumpAddress;
    logic [DataWidth-1:0] nextPc;
    logic                 branchTaken;

    assign pcPlusFour = pc + DataWidth'(4);

    // pc + 4 + (imm << 2)
    assign branchTarget = pcPlusFour + {immExt[DataWidth-3:0], 2'b00};

    // {(pc + 4)[31:28], target << 2}
    assign jumpAddress = {pcPlusFour[DataWidth-1:28], jumpTarget, 2'b00};

    // beq on equal, bne on not equal
    assign branchTaken = (ctrl.branch & zero) | (ctrl.branchNe & ~zero);

    always_comb begin
        if (ctrl.jumpRegister) begin
            nextPc = rsData;
        end else if (ctrl.jump) begin
            nextPc = jumpAddress;
        end else if (branchTaken) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlusFour;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

// File: rtl/instrMem.sv
`timescale 1ns/10ps

module instrMem import mipsPkg::*; #(
    parameter int ImemDepth = 256
) (
    input  logic                 clk,
    input  logic [DataWidth-1:0] addr,
    output logic [DataWidth-1:0] instruction,
    input  logic                 loadEn,
    input  logic [DataWidth-1:0] loadAddr,
    input  logic [DataWidth-1:0] loadData
);

    // depth is taken as a power of two so the index wraps
    localparam int IdxWidth = $clog2(ImemDepth);

    logic [DataWidth-1:0] mem [ImemDepth];

    // empty words decode as sll $0, $0, 0
    initial begin
        for (int i = 0; i < ImemDepth; i++) begin
            mem[i] = '0;
        end
    end

    // pc is a byte address
    assign instruction = mem[addr[IdxWidth+1:2]];

    // loader addresses words directly
    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[loadAddr[IdxWidth-1:0]] <= loadData;
        end
    end

endmodule

// File: rtl/mipsAlu.sv
`timescale 1ns/10ps

module mipsAlu import mipsPkg::*; (
    input  ctrlT                 ctrl,
    input  logic [DataWidth-1:0] rsData,
    input  logic [DataWidth-1:0] rtData,
    input  logic [DataWidth-1:0] immExt,
    input  logic [4:0]           shamt,
    output logic [DataWidth-1:0] result,
    output logic                 zero
);

    logic [DataWidth-1:0] operandA;
    logic [DataWidth-1:0] operandB;
    logic                 lessThan;

    // sll takes the shift amount as operand a
    always_comb begin
        if (ctrl.shiftLeftLogical) begin
            operandA = {{(DataWidth-5){1'b0}}, shamt};
        end else begin
            operandA = rsData;
        end
    end

    always_comb begin
        if (ctrl.aluSrc) begin
            operandB = immExt;
        end else begin
            operandB = rtData;
        end
    end

    // signed compare for slt
    assign lessThan = $signed(operandA) < $signed(operandB);

    always_comb begin
        case (ctrl.aluOp)
            aluAdd: result = operandA + operandB;
            aluSub: result = operandA - operandB;
            aluAnd: result = operandA & operandB;
            aluOr:  result = operandA | operandB;
            aluSlt: result = {{(DataWidth-1){1'b0}}, lessThan};
            // rt shifted by shamt
            aluSll: result = operandB << operandA[4:0];
            default: result = '0;
        endcase
    end

    // used by beq and bne
    assign zero = (result == '0);

endmodule

// File: rtl/mipsPkg.sv
package mipsPkg;

    // machine word and register index widths
    localparam int DataWidth    = 32;
    localparam int RegAddrWidth = 5;

    // primary opcodes, instruction[31:26]
    typedef enum logic [5:0] {
        opRType = 6'h00,
        opJ     = 6'h02,
        opJal   = 6'h03,
        opBeq   = 6'h04,
        opBne   = 6'h05,
        opAddi  = 6'h08,
        opLui   = 6'h0f,
        opLw    = 6'h23,
        opSw    = 6'h2b
    } opcodeT;

    // r-type function codes, instruction[5:0]
    typedef enum logic [5:0] {
        fnSll = 6'h00,
        fnJr  = 6'h08,
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2a
    } functT;

    // operation performed by the alu
    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4,
        aluSll = 3'd5
    } aluOpT;

    // decoded control for one instruction
    typedef struct packed {
        // write to rd instead of rt
        logic  regDst;
        logic  jump;
        // link into $ra
        logic  jumpAndLink;
        logic  jumpRegister;
        // beq
        logic  branch;
        // bne
        logic  branchNe;
        logic  memWrite;
        logic  memtoReg;
        // operand b from the immediate
        logic  aluSrc;
        logic  regWrite;
        // operand a from shamt
        logic  shiftLeftLogical;
        logic  loadUpperImmediate;
        aluOpT aluOp;
    } ctrlT;

endpackage

// File: rtl/opcodeControl.sv
`timescale 1ns/10ps

module opcodeControl import mipsPkg::*; (
    input  opcodeT opcode,
    input  functT  funct,
    output ctrlT   ctrl
);

    always_comb begin
        // unknown codes fall through as a nop
        ctrl = '0;
        case (opcode)
            opRType: begin
                case (funct)
                    fnAdd: begin
                        ctrl.regDst   = 1'b1;
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = aluAdd;
                    end
                    fnSub: begin
                        ctrl.regDst   = 1'b1;
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = aluSub;
                    end
                    fnAnd: begin
                        ctrl.regDst   = 1'b1;
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = aluAnd;
                    end
                    fnOr: begin
                        ctrl.regDst   = 1'b1;
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = aluOr;
                    end
                    fnSlt: begin
                        ctrl.regDst   = 1'b1;
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = aluSlt;
                    end
                    fnSll: begin
                        ctrl.regDst           = 1'b1;
                        ctrl.regWrite         = 1'b1;
                        ctrl.shiftLeftLogical = 1'b1;
                        ctrl.aluOp            = aluSll;
                    end
                    fnJr: begin
                        ctrl.jumpRegister = 1'b1;
                    end
                    default: ctrl = '0;
                endcase
            end
            opAddi: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluAdd;
            end
            opLui: begin
                ctrl.regWrite           = 1'b1;
                ctrl.loadUpperImmediate = 1'b1;
            end
            opLw: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memtoReg = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluAdd;
            end
            opSw: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.aluOp    = aluAdd;
            end
            // compare by subtraction, zero flag decides
            opBeq: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = aluSub;
            end
            opBne: begin
                ctrl.branchNe = 1'b1;
                ctrl.aluOp    = aluSub;
            end
            opJ: ctrl.jump = 1'b1;
            opJal: begin
                ctrl.jump        = 1'b1;
                ctrl.jumpAndLink = 1'b1;
                ctrl.regWrite    = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

// File: rtl/regFile.sv
`timescale 1ns/10ps

module regFile import mipsPkg::*; (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic [RegAddrWidth-1:0] readRegister1,
    input  logic [RegAddrWidth-1:0] readRegister2,
    input  logic [RegAddrWidth-1:0] writeRegister,
    input  logic [DataWidth-1:0]    writeData,
    input  logic                    writeEnable,
    output logic [DataWidth-1:0]    readData1,
    output logic [DataWidth-1:0]    readData2,
    input  logic [RegAddrWidth-1:0] readRegisterDebug,
    output logic [DataWidth-1:0]    readDataDebug
);

    logic [DataWidth-1:0] regs [2**RegAddrWidth];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 2**RegAddrWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeRegister != '0) begin
            regs[writeRegister] <= writeData;
        end
    end

    // $zero reads 0 regardless of array contents
    assign readData1     = (readRegister1 == '0) ? '0 : regs[readRegister1];
    assign readData2     = (readRegister2 == '0) ? '0 : regs[readRegister2];
    assign readDataDebug = (readRegisterDebug == '0) ? '0 : regs[readRegisterDebug];

endmodule

// File: rtl/singleCycleCpu.sv
`timescale 1ns/10ps

module singleCycleCpu import mipsPkg::*; #(
    parameter int ImemDepth = 256,
    parameter int DmemDepth = 256
) (
    input  logic                    clk,
    input  logic                    arstN,
    output logic [DataWidth-1:0]    instruction,
    output logic [DataWidth-1:0]    pcOut,
    input  logic [RegAddrWidth-1:0] readRegisterDebug,
    output logic [DataWidth-1:0]    readDataDebug,
    input  logic                    imemWriteEn,
    input  logic [DataWidth-1:0]    imemAddr,
    input  logic [DataWidth-1:0]    imemData
);

    // instruction fields
    opcodeT                  opcode;
    functT                   funct;
    logic [RegAddrWidth-1:0] rs;
    logic [RegAddrWidth-1:0] rt;
    logic [RegAddrWidth-1:0] rd;
    logic [4:0]              shamt;
    logic [15:0]             imm;
    logic [25:0]             jumpTarget;
    logic [DataWidth-1:0]    immExt;
    logic [DataWidth-1:0]    upperImm;

    ctrlT                    ctrl;
    logic [DataWidth-1:0]    pcPlusFour;
    logic [DataWidth-1:0]    rsData;
    logic [DataWidth-1:0]    rtData;
    logic [DataWidth-1:0]    aluResult;
    logic                    aluZero;
    logic [DataWidth-1:0]    memReadData;
    logic [RegAddrWidth-1:0] writeRegister;
    logic [DataWidth-1:0]    writeData;
    logic                    regWriteEn;
    logic                    memWriteEn;

    assign opcode     = opcodeT'(instruction[31:26]);
    assign rs         = instruction[25:21];
    assign rt         = instruction[20:16];
    assign rd         = instruction[15:11];
    assign shamt      = instruction[10:6];
    assign funct      = functT'(instruction[5:0]);
    assign imm        = instruction[15:0];
    assign jumpTarget = instruction[25:0];

    assign immExt   = {{(DataWidth-16){imm[15]}}, imm};
    assign upperImm = {imm, 16'h0000};

    // no register or memory write while held in reset
    assign regWriteEn = ctrl.regWrite & arstN;
    assign memWriteEn = ctrl.memWrite & arstN;

    // $ra for jal, otherwise rd or rt
    always_comb begin
        if (ctrl.jumpAndLink) begin
            writeRegister = RegAddrWidth'(31);
        end else if (ctrl.regDst) begin
            writeRegister = rd;
        end else begin
            writeRegister = rt;
        end
    end

    // write-back priority: lui, jal link, load, alu
    always_comb begin
        if (ctrl.loadUpperImmediate) begin
            writeData = upperImm;
        end else if (ctrl.jumpAndLink) begin
            writeData = pcPlusFour;
        end else if (ctrl.memtoReg) begin
            writeData = memReadData;
        end else begin
            writeData = aluResult;
        end
    end

    fetchUnit i_fetchUnit (
        .clk        (clk),
        .arstN      (arstN),
        .ctrl       (ctrl),
        .zero       (aluZero),
        .rsData     (rsData),
        .immExt     (immExt),
        .jumpTarget (jumpTarget),
        .pc         (pcOut),
        .pcPlusFour (pcPlusFour)
    );

    instrMem #(
        .ImemDepth (ImemDepth)
    ) i_instrMem (
        .clk         (clk),
        .addr        (pcOut),
        .instruction (instruction),
        .loadEn      (imemWriteEn),
        .loadAddr    (imemAddr),
        .loadData    (imemData)
    );

    opcodeControl i_opcodeControl (
        .opcode (opcode),
        .funct  (funct),
        .ctrl   (ctrl)
    );

    regFile i_regFile (
        .clk               (clk),
        .arstN             (arstN),
        .readRegister1     (rs),
        .readRegister2     (rt),
        .writeRegister     (writeRegister),
        .writeData         (writeData),
        .writeEnable       (regWriteEn),
        .readData1         (rsData),
        .readData2         (rtData),
        .readRegisterDebug (readRegisterDebug),
        .readDataDebug     (readDataDebug)
    );

    mipsAlu i_mipsAlu (
        .ctrl   (ctrl),
        .rsData (rsData),
        .rtData (rtData),
        .immExt (immExt),
        .shamt  (shamt),
        .result (aluResult),
        .zero   (aluZero)
    );

    // sw stores rt at rs + imm
    dataMem #(
        .DmemDepth (DmemDepth)
    ) i_dataMem (
        .clk         (clk),
        .address     (aluResult),
        .writeEnable (memWriteEn),
        .writeData   (rtData),
        .readData    (memReadData)
    );

endmodule

// File: sim.f
rtl/mipsPkg.sv
rtl/fetchUnit.sv
rtl/instrMem.sv
rtl/opcodeControl.sv
rtl/regFile.sv
rtl/mipsAlu.sv
rtl/dataMem.sv
rtl/singleCycleCpu.sv
sim/clockGen.sv
sim/tbSingleCycleCpu.sv

// File: sim/clockGen.sv
`timescale 1ns/10ps

module clockGen #(
    parameter int Period      = 4,
    parameter int ResetCycles = 2
) (
    input  logic holdReset,
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #(Period / 2) clk = ~clk;
    end

    // low while holdReset is set, released 1 ns after the second edge once it drops
    initial begin
        arstN = 1'b0;
        forever begin
            wait (holdReset === 1'b0);
            repeat (ResetCycles) @(posedge clk);
            #1 arstN = 1'b1;
            wait (holdReset === 1'b1);
            arstN = 1'b0;
        end
    end

endmodule

// File: sim/tbSingleCycleCpu.sv
`timescale 1ns/10ps

module tbSingleCycleCpu import mipsPkg::*; ();

    localparam int Period        = 4;
    localparam int NumTests      = 6;
    localparam int CyclesPerTest = 120;
    // loader window, cleared on every load
    localparam int ProgWords     = 32;
    // beq $0, $0, -1 spins in place
    localparam logic [31:0] HaltWord = 32'h1000_ffff;

    logic        clk;
    logic        arstN;
    logic        holdReset;
    logic [31:0] instruction;
    logic [31:0] pcOut;
    logic [4:0]  readRegisterDebug;
    logic [31:0] readDataDebug;
    logic        imemWriteEn;
    logic [31:0] imemAddr;
    logic [31:0] imemData;

    logic [31:0] prog [$];
    integer      seed        = 32'hf4dc2172;
    int          errors      = 0;
    int          checks      = 0;
    int          testsRun    = 0;
    int          testsFailed = 0;

    clockGen #(
        .Period (Period)
    ) i_clockGen (
        .holdReset (holdReset),
        .clk       (clk),
        .arstN     (arstN)
    );

    singleCycleCpu i_dut (
        .clk               (clk),
        .arstN             (arstN),
        .instruction       (instruction),
        .pcOut             (pcOut),
        .readRegisterDebug (readRegisterDebug),
        .readDataDebug     (readDataDebug),
        .imemWriteEn       (imemWriteEn),
        .imemAddr          (imemAddr),
        .imemData          (imemData)
    );

    function automatic logic [31:0] encR(input logic [4:0] rs, rt, rd, shamt, input functT fn);
        return {opRType, rs, rt, rd, shamt, fn};
    endfunction

    function automatic logic [31:0] encI(input opcodeT op, input logic [4:0] rs, rt,
                                         input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encJ(input opcodeT op, input logic [25:0] target);
        return {op, target};
    endfunction

    function automatic logic [31:0] signExt(input logic [15:0] value);
        return {{16{value[15]}}, value};
    endfunction

    function automatic logic [31:0] branchDest(input logic [31:0] pc, input logic [15:0] imm);
        return pc + 32'd4 + (signExt(imm) << 2);
    endfunction

    function automatic logic [31:0] jumpDest(input logic [31:0] pc, input logic [25:0] target);
        logic [31:0] nextPc;
        nextPc = pc + 32'd4;
        return {nextPc[31:28], target, 2'b00};
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s: expected %08h, got %08h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic checkReg(input int idx, input logic [31:0] expected);
        @(posedge clk);
        #1;
        readRegisterDebug = 5'(idx);
        #1;
        checkValue($sformatf("r%0d", idx), expected, readDataDebug);
    endtask

    // core sits in reset while the window is written
    task automatic loadProgram();
        @(posedge clk);
        #1;
        holdReset = 1'b1;
        for (int i = 0; i < ProgWords; i++) begin
            @(posedge clk);
            #1;
            imemWriteEn = 1'b1;
            imemAddr    = i;
            imemData    = (i < prog.size()) ? prog[i] : 32'h0;
        end
        @(posedge clk);
        #1;
        imemWriteEn = 1'b0;
        holdReset   = 1'b0;
        checkValue("pcOut", 32'h0, pcOut);
        checkValue("instruction", prog[0], instruction);
        wait (arstN === 1'b1);
    endtask

    task automatic runCycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        testsRun++;
        if (errors != errorsBefore) begin
            testsFailed++;
        end
        $display("%-10s done, %0d errors", name, errors - errorsBefore);
    endtask

    task automatic testReset();
        int errorsBefore = errors;
        prog = {};
        for (int i = 0; i < 5; i++) begin
            prog.push_back(encI(opAddi, 5'd1, 5'd1, 16'd1));
        end
        prog.push_back(HaltWord);
        loadProgram();
        for (int n = 1; n <= 5; n++) begin
            runCycles(1);
            checkValue("pcOut", 32'(4 * n), pcOut);
        end
        checkReg(1, 32'd5);
        finishTest("reset", errorsBefore);
    endtask

    task automatic testArithmetic();
        int          errorsBefore = errors;
        logic [31:0] a = signExt(16'h1234);
        logic [31:0] b = signExt(16'hfff9);
        prog = {};
        prog.push_back(encI(opAddi, 5'd0, 5'd1, 16'h1234));
        prog.push_back(encI(opAddi, 5'd0, 5'd2, 16'hfff9));
        prog.push_back(encR(5'd1, 5'd2, 5'd3, 5'd0, fnAdd));
        prog.push_back(encR(5'd1, 5'd2, 5'd4, 5'd0, fnSub));
        prog.push_back(encR(5'd1, 5'd2, 5'd5, 5'd0, fnAnd));
        prog.push_back(encR(5'd1, 5'd2, 5'd6, 5'd0, fnOr));
        prog.push_back(encR(5'd2, 5'd1, 5'd7, 5'd0, fnSlt));
        prog.push_back(encR(5'd1, 5'd2, 5'd8, 5'd0, fnSlt));
        prog.push_back(encR(5'd0, 5'd1, 5'd9, 5'd4, fnSll));
        prog.push_back(encI(opLui, 5'd0, 5'd10, 16'habcd));
        prog.push_back(encI(opAddi, 5'd0, 5'd0, 16'h0009));
        prog.push_back(HaltWord);
        loadProgram();
        runCycles(prog.size());
        checkReg(3, a + b);
        checkReg(4, a - b);
        checkReg(5, a & b);
        checkReg(6, a | b);
        // negative operand on the left
        checkReg(7, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
        checkReg(8, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        checkReg(9, a << 4);
        checkReg(10, {16'habcd, 16'h0000});
        checkReg(0, 32'd0);
        finishTest("arith", errorsBefore);
    endtask

    task automatic testMemory();
        int errorsBefore = errors;
        prog = {};
        prog.push_back(encI(opAddi, 5'd0, 5'd1, 16'h55aa));
        prog.push_back(encI(opAddi, 5'd0, 5'd2, 16'h8001));
        prog.push_back(encI(opAddi, 5'd0, 5'd5, 16'h0007));
        prog.push_back(encI(opSw, 5'd0, 5'd1, 16'd8));
        prog.push_back(encI(opSw, 5'd0, 5'd2, 16'd20));
        prog.push_back(encI(opLw, 5'd0, 5'd3, 16'd8));
        prog.push_back(encI(opLw, 5'd0, 5'd4, 16'd20));
        // never written, overwrites the 7 in r5
        prog.push_back(encI(opLw, 5'd0, 5'd5, 16'd40));
        prog.push_back(HaltWord);
        loadProgram();
        runCycles(prog.size());
        checkReg(3, signExt(16'h55aa));
        checkReg(4, signExt(16'h8001));
        checkReg(5, 32'd0);
        finishTest("memory", errorsBefore);
    endtask

    task automatic testBranches();
        int errorsBefore = errors;
        prog = {};
        prog.push_back(encI(opAddi, 5'd0, 5'd1, 16'd3));
        prog.push_back(encI(opAddi, 5'd0, 5'd2, 16'd3));
        prog.push_back(encI(opAddi, 5'd0, 5'd3, 16'd4));
        prog.push_back(encI(opBeq, 5'd1, 5'd3, 16'd1));
        prog.push_back(encI(opAddi, 5'd0, 5'd10, 16'd1));
        prog.push_back(encI(opBeq, 5'd1, 5'd2, 16'd1));
        prog.push_back(encI(opAddi, 5'd0, 5'd11, 16'd1));
        prog.push_back(encI(opBne, 5'd1, 5'd2, 16'd1));
        prog.push_back(encI(opAddi, 5'd0, 5'd12, 16'd1));
        prog.push_back(encI(opBne, 5'd1, 5'd3, 16'd1));
        prog.push_back(encI(opAddi, 5'd0, 5'd13, 16'd1));
        prog.push_back(HaltWord);
        loadProgram();
        // beq not taken, then beq taken at 20
        runCycles(6);
        checkValue("pcOut", branchDest(32'd20, 16'd1), pcOut);
        // bne not taken, then bne taken at 36
        runCycles(3);
        checkValue("pcOut", branchDest(32'd36, 16'd1), pcOut);
        checkReg(10, 32'd1);
        checkReg(11, 32'd0);
        checkReg(12, 32'd1);
        checkReg(13, 32'd0);
        finishTest("branches", errorsBefore);
    endtask

    task automatic testJumps();
        int errorsBefore = errors;
        prog = {};
        prog.push_back(encJ(opJ, 26'd2));
        prog.push_back(encI(opAddi, 5'd0, 5'd10, 16'd1));
        prog.push_back(encJ(opJal, 26'd5));
        prog.push_back(encI(opAddi, 5'd0, 5'd11, 16'd1));
        prog.push_back(HaltWord);
        prog.push_back(encI(opAddi, 5'd0, 5'd12, 16'd1));
        prog.push_back(encR(5'd31, 5'd0, 5'd0, 5'd0, fnJr));
        loadProgram();
        runCycles(1);
        checkValue("pcOut", jumpDest(32'd0, 26'd2), pcOut);
        runCycles(1);
        checkValue("pcOut", jumpDest(32'd8, 26'd5), pcOut);
        // subroutine body, then jr back past the jal
        runCycles(2);
        checkValue("pcOut", 32'd8 + 32'd4, pcOut);
        runCycles(2);
        checkValue("pcOut", 32'd16, pcOut);
        checkReg(31, 32'd8 + 32'd4);
        checkReg(10, 32'd0);
        checkReg(11, 32'd1);
        checkReg(12, 32'd1);
        finishTest("jumps", errorsBefore);
    endtask

    task automatic testRandomAdds();
        int          errorsBefore = errors;
        logic [15:0] imm [4];
        logic [31:0] sumA;
        logic [31:0] sumB;
        for (int k = 0; k < 4; k++) begin
            imm[k] = 16'($random(seed));
        end
        sumA = signExt(imm[0]) + signExt(imm[1]);
        sumB = signExt(imm[2]) + signExt(imm[3]);
        prog = {};
        prog.push_back(encI(opAddi, 5'd0, 5'd1, imm[0]));
        prog.push_back(encI(opAddi, 5'd1, 5'd1, imm[1]));
        prog.push_back(encI(opAddi, 5'd0, 5'd2, imm[2]));
        prog.push_back(encI(opAddi, 5'd2, 5'd2, imm[3]));
        prog.push_back(encR(5'd1, 5'd2, 5'd3, 5'd0, fnAdd));
        prog.push_back(HaltWord);
        loadProgram();
        runCycles(prog.size());
        checkReg(1, sumA);
        checkReg(2, sumB);
        checkReg(3, sumA + sumB);
        finishTest("random", errorsBefore);
    endtask

    initial begin
        #(NumTests * CyclesPerTest * Period);
        $display("run timed out after %0d ns without finishing the tests", $time);
        $display("Test failed");
        $finish;
    end

    initial begin
        holdReset         = 1'b1;
        readRegisterDebug = '0;
        imemWriteEn       = 1'b0;
        imemAddr          = '0;
        imemData          = '0;
        testReset();
        testArithmetic();
        testMemory();
        testBranches();
        testJumps();
        testRandomAdds();
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 testsRun, testsFailed, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
